/* verif/frontend_stim.txt */
# name, then da pg plv dmw0 dmw1 flush_pc blocks stall_mask first_ecode, all hex but blocks
# stall_mask drives one stall bit per cycle from bit 0 and repeats every 16 cycles
da_seq       1 0 0 00000000 00000000 1c000100  6 0000 0
da_cross     1 0 0 00000000 00000000 1c00000c  8 0000 0
da_over_pg   1 1 0 80000001 00000000 80000100  4 0000 0
dmw1_kern    0 1 0 00000000 80000001 9c000004  6 0000 0
dmw1_user    0 1 3 00000000 a2000008 a0001004  6 0000 0
dmw0_prio    0 1 0 80000001 86000001 80000ff4  6 0000 0
dmw0_prio_b  0 1 0 8a000001 80000001 80002000  4 0000 0
adef_align   1 0 0 00000000 00000000 1c000002  3 0000 1
adef_user    0 1 3 00000000 00000000 90000000  3 0000 1
tlbr_miss    0 1 0 80000001 00000000 40000000  3 0000 2
tlbr_user    0 1 3 80000008 00000000 00400000  3 0000 2
stall_a      1 0 0 00000000 00000000 1c000204 12 5a3c 0
stall_b      1 0 0 00000000 00000000 1c00040c 12 9249 0
stall_c      0 1 0 80000001 00000000 80000804 16 ffe0 0
flush_back   1 0 0 00000000 00000000 1c000000  6 7777 0
stall_d      1 0 0 00000000 00000000 1c00100c 10 f0f0 0
adef_stall   1 0 0 00000000 00000000 1c000201  4 3c3c 1
dmw1_stall   0 1 3 00000000 a2000008 a000200c  8 a5a5 0

/* verilog.f */
logic/fetch_pkg.sv
logic/csr_pkg.sv
logic/pc_gen.sv
logic/ftq.sv
logic/addr_xlate.sv
logic/ifu.sv
logic/frontend.sv
verif/tb_clk_gen.sv
verif/frontend_chk.sv
verif/tb_frontend.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the frontend testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    -f verilog.f \
    --top-module tb_frontend \
    -o sim_frontend

./obj_dir/sim_frontend | tee sim.log

if grep -qx "Simulation PASSED" sim.log; then
    echo "Run result: pass"
else
    echo "Run result: fail, see sim.log"
    exit 1
fi

/* verif/tb_frontend.sv */
`timescale 1ns/10ps

module tb_frontend;

    localparam fetch_pkg::addr_t RESET_PC  = 32'h1c00_0000;
    localparam int               FTQ_DEPTH = 4;
    localparam logic [31:0]      WORD_XOR  = 32'ha5a5_0000;
    localparam int               TIMEOUT   = 200;

    logic clk;
    logic rst_n;

    logic                    flush_i;
    fetch_pkg::addr_t        flush_pc_i;
    logic                    ib_stall_i;
    logic                    csr_da_i;
    logic                    csr_pg_i;
    csr_pkg::plv_t           csr_plv_i;
    csr_pkg::csr_word_t      csr_dmw0_i;
    csr_pkg::csr_word_t      csr_dmw1_i;
    logic [1:0]              icache_rd_req_o;
    fetch_pkg::addr_t [1:0]  icache_rd_addr_o;
    logic [1:0]              icache_rd_valid_i;
    fetch_pkg::line_t [1:0]  icache_rd_data_i;
    logic [1:0]              ib_valid_o;
    fetch_pkg::addr_t [1:0]  ib_pc_o;
    fetch_pkg::instr_t [1:0] ib_instr_o;
    fetch_pkg::ecode_t       ib_ecode_o;

    logic [15:0] stall_pat;
    logic        aborted;
    int          checks;
    int          errors;

    // Most recent ICache request, belongs to the block being delivered
    logic [1:0]             last_req;
    fetch_pkg::addr_t [1:0] last_addr;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    frontend #(
        .RESET_PC  (RESET_PC),
        .FTQ_DEPTH (FTQ_DEPTH)
    ) UUT (
        .clk               (clk),
        .rst_n             (rst_n),
        .flush_i           (flush_i),
        .flush_pc_i        (flush_pc_i),
        .ib_stall_i        (ib_stall_i),
        .csr_da_i          (csr_da_i),
        .csr_pg_i          (csr_pg_i),
        .csr_plv_i         (csr_plv_i),
        .csr_dmw0_i        (csr_dmw0_i),
        .csr_dmw1_i        (csr_dmw1_i),
        .icache_rd_req_o   (icache_rd_req_o),
        .icache_rd_addr_o  (icache_rd_addr_o),
        .icache_rd_valid_i (icache_rd_valid_i),
        .icache_rd_data_i  (icache_rd_data_i),
        .ib_valid_o        (ib_valid_o),
        .ib_pc_o           (ib_pc_o),
        .ib_instr_o        (ib_instr_o),
        .ib_ecode_o        (ib_ecode_o)
    );

    // Every word holds its own physical address XOR a constant
    function automatic fetch_pkg::line_t make_line(input fetch_pkg::addr_t addr);
        fetch_pkg::line_t line;
        for (int w = 0; w < 4; w++) begin
            line[w*32 +: 32] = ({addr[31:4], 4'b0000} + 32'(w * 4)) ^ WORD_XOR;
        end
        return line;
    endfunction

    function automatic logic window_hit(input logic [31:0] dmw, input fetch_pkg::addr_t va);
        logic level_ok;
        level_ok = (dmw[0] && (csr_plv_i == 2'd0)) || (dmw[3] && (csr_plv_i == 2'd3));
        return level_ok && (dmw[31:29] == va[31:29]);
    endfunction

    // Expected {ecode, physical address} of a fetch address
    function automatic logic [35:0] translate(input fetch_pkg::addr_t va);
        logic hit0;
        logic hit1;
        logic mapped;
        hit0   = csr_pg_i && window_hit(csr_dmw0_i, va);
        hit1   = csr_pg_i && window_hit(csr_dmw1_i, va);
        mapped = csr_pg_i && !csr_da_i && !hit0 && !hit1;
        if ((va[1:0] != 2'b00) || ((csr_plv_i == 2'd3) && va[31] && mapped)) begin
            return {4'b0001, va};
        end
        if (csr_da_i) begin
            return {4'b0000, va};
        end
        if (hit0) begin
            return {4'b0000, csr_dmw0_i[27:25], va[28:0]};
        end
        if (hit1) begin
            return {4'b0000, csr_dmw1_i[27:25], va[28:0]};
        end
        return {4'b0010, va};
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s %s: expected %h, actual %h", test, what, expected, actual);
        end
    endtask

    // Stall mask replays one bit per cycle
    initial begin : stall_driver
        logic [3:0] idx;
        idx = '0;
        ib_stall_i <= 1'b0;
        forever begin
            @(posedge clk);
            ib_stall_i <= stall_pat[idx];
            idx = idx + 4'd1;
        end
    end

    // ICache with 1 to 4 cycles latency per port
    initial begin : icache_model
        int unsigned      lat [2];
        logic [1:0]       busy;
        fetch_pkg::addr_t addr [2];
        void'($urandom(32'hf4bc));
        busy = '0;
        last_req  = '0;
        last_addr = '0;
        icache_rd_valid_i <= '0;
        icache_rd_data_i  <= '0;
        forever begin
            @(posedge clk);
            if (icache_rd_req_o != 2'b00) begin
                last_req  = icache_rd_req_o;
                last_addr = icache_rd_addr_o;
            end
            for (int p = 0; p < 2; p++) begin
                icache_rd_valid_i[p] <= 1'b0;
                if (icache_rd_req_o[p]) begin
                    busy[p] = 1'b1;
                    addr[p] = icache_rd_addr_o[p];
                    lat[p]  = $urandom_range(4, 1);
                end
                if (busy[p]) begin
                    lat[p] = lat[p] - 1;
                    if (lat[p] == 0) begin
                        icache_rd_valid_i[p] <= 1'b1;
                        icache_rd_data_i[p]  <= make_line(addr[p]);
                        busy[p] = 1'b0;
                    end
                end
            end
        end
    end

    task automatic wait_delivery(output logic ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && (cycles < TIMEOUT)) begin
            @(negedge clk);
            if (ib_valid_o != 2'b00) begin
                ok = 1'b1;
            end else begin
                cycles++;
            end
        end
    endtask

    task automatic wait_read(output logic ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && (cycles < TIMEOUT)) begin
            @(negedge clk);
            if (icache_rd_req_o != 2'b00) begin
                ok = 1'b1;
            end else begin
                cycles++;
            end
        end
    endtask

    // Blocks must arrive in order from start_pc with no gaps
    task automatic run_blocks(input string name, input fetch_pkg::addr_t start_pc,
                              input int n, input fetch_pkg::ecode_t first_ecode);
        fetch_pkg::addr_t  va;
        fetch_pkg::addr_t  pa;
        fetch_pkg::ecode_t ec;
        logic [35:0]       xl;
        logic              ok;
        for (int k = 0; k < n; k++) begin
            wait_delivery(ok);
            if (!ok) begin
                errors++;
                $display("ERROR: test %s: block %0d not delivered within %0d cycles",
                         name, k, TIMEOUT);
                aborted = 1'b1;
                return;
            end
            va = start_pc + (fetch_pkg::addr_t'(k) << 3);
            xl = translate(va);
            ec = xl[35:32];
            pa = xl[31:0];
            if (k == 0) begin
                check_value(name, "first ecode", 32'(first_ecode), 32'(ib_ecode_o));
            end
            check_value(name, "pc0", va, ib_pc_o[0]);
            check_value(name, "ecode", 32'(ec), 32'(ib_ecode_o));
            if (ec == 4'b0000) begin
                check_value(name, "valid", 32'd3, 32'(ib_valid_o));
                check_value(name, "pc1", va + 32'd4, ib_pc_o[1]);
                check_value(name, "instr0", pa ^ WORD_XOR, ib_instr_o[0]);
                check_value(name, "instr1", (pa + 32'd4) ^ WORD_XOR, ib_instr_o[1]);
                // Port 1 only for a block whose second word lies in the next line
                check_value(name, "rd_req", {30'd0, &va[3:2], 1'b1}, 32'(last_req));
                check_value(name, "rd_addr0", {pa[31:4], 4'b0000}, last_addr[0]);
                if (&va[3:2]) begin
                    check_value(name, "rd_addr1", {pa[31:4], 4'b0000} + 32'd16,
                                last_addr[1]);
                end
            end else begin
                check_value(name, "valid", 32'd1, 32'(ib_valid_o));
                check_value(name, "instr0", 32'd0, ib_instr_o[0]);
                check_value(name, "instr1", 32'd0, ib_instr_o[1]);
            end
        end
    endtask

    initial begin : main_seq
        int               fd;
        int               fields;
        int               tests;
        int               cycles;
        int               f_blocks;
        logic             ok;
        logic             prev_fault;
        logic [8*160-1:0] line_buf;
        logic [8*32-1:0]  name_buf;
        logic [31:0]      f_da;
        logic [31:0]      f_pg;
        logic [31:0]      f_plv;
        logic [31:0]      f_dmw0;
        logic [31:0]      f_dmw1;
        logic [31:0]      f_target;
        logic [31:0]      f_stall;
        logic [31:0]      f_ecode;
        string            name;

        flush_i    <= 1'b0;
        flush_pc_i <= '0;
        csr_da_i   <= 1'b1;
        csr_pg_i   <= 1'b0;
        csr_plv_i  <= 2'd0;
        csr_dmw0_i <= '0;
        csr_dmw1_i <= '0;
        stall_pat  <= '0;
        aborted    = 1'b0;
        checks     = 0;
        errors     = 0;
        tests      = 0;
        prev_fault = 1'b0;

        cycles = 0;
        while ((rst_n !== 1'b1) && (cycles < 100)) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            errors++;
            $display("ERROR: reset was never released");
            aborted = 1'b1;
        end else begin
            @(negedge clk);
            check_value("reset", "ib_valid", 32'd0, 32'(ib_valid_o));
            check_value("reset", "rd_req", 32'd0, 32'(icache_rd_req_o));
            run_blocks("reset_seq", RESET_PC, 4, 4'h0);
        end

        fd = $fopen("verif/frontend_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("ERROR: cannot open the stimulus file verif/frontend_stim.txt");
        end else begin
            while (!aborted && !$feof(fd)) begin
                line_buf = '0;
                if ($fgets(line_buf, fd) != 0) begin
                    fields = $sscanf(line_buf, "%s %h %h %h %h %h %h %d %h %h",
                                     name_buf, f_da, f_pg, f_plv, f_dmw0, f_dmw1,
                                     f_target, f_blocks, f_stall, f_ecode);
                    if (fields == 10) begin
                        name = $sformatf("%0s", name_buf);
                        // Flush while a read is still outstanding
                        if (!prev_fault) begin
                            wait_read(ok);
                            if (!ok) begin
                                errors++;
                                $display("ERROR: test %s: no ICache read seen before the flush",
                                         name);
                            end
                        end
                        @(posedge clk);
                        csr_da_i   <= f_da[0];
                        csr_pg_i   <= f_pg[0];
                        csr_plv_i  <= f_plv[1:0];
                        csr_dmw0_i <= f_dmw0;
                        csr_dmw1_i <= f_dmw1;
                        stall_pat  <= f_stall[15:0];
                        flush_pc_i <= f_target;
                        flush_i    <= 1'b1;
                        @(posedge clk);
                        flush_i    <= 1'b0;
                        run_blocks(name, f_target, f_blocks, f_ecode[3:0]);
                        prev_fault = (f_ecode != 32'd0);
                        tests++;
                    end
                end
            end
            $fclose(fd);
            if (tests == 0) begin
                errors++;
                $display("ERROR: no test case was read from the stimulus file");
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* verif/frontend_chk.sv */
`timescale 1ns/10ps

module frontend_chk (
    input logic                              clk,
    input logic                              rst_n,

    // Queue side
    input logic                              enq_valid_i,
    input logic                              full_i,

    // IFU side
    input logic                              ib_stall_i,
    input logic [fetch_pkg::FETCH_WIDTH-1:0] ib_valid_i,
    input fetch_pkg::ifu_state_e             state_i,
    input logic [1:0]                        rd_req_i
);

    a_no_enq_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(enq_valid_i && full_i))
        else $error("FTQ enqueue while the queue is full");

    a_no_valid_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
        ib_stall_i |-> (ib_valid_i == '0))
        else $error("Instruction buffer valid raised during a stall");

    // Slot 1 only ever comes with slot 0
    a_slot_order: assert property (@(posedge clk) disable iff (!rst_n)
        ib_valid_i[1] |-> ib_valid_i[0])
        else $error("Slot 1 valid without slot 0");

    a_no_req_in_drain: assert property (@(posedge clk) disable iff (!rst_n)
        (state_i == fetch_pkg::DRAIN) |-> (rd_req_i == 2'b00))
        else $error("ICache request issued in DRAIN");

endmodule

bind ftq frontend_chk u_queue_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .enq_valid_i (enq_valid_i),
    .full_i      (full_o),
    .ib_stall_i  (1'b0),
    .ib_valid_i  ('0),
    .state_i     (fetch_pkg::IDLE),
    .rd_req_i    (2'b00)
);

bind ifu frontend_chk u_ifu_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .enq_valid_i (1'b0),
    .full_i      (1'b0),
    .ib_stall_i  (ib_stall_i),
    .ib_valid_i  (ib_valid_o),
    .state_i     (state_q),
    .rd_req_i    (icache_rd_req_o)
);

/* verif/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Reset low for the first 16 cycles
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* logic/frontend.sv */
`timescale 1ns/10ps

module frontend #(
    parameter fetch_pkg::addr_t RESET_PC  = 32'h1c00_0000,
    parameter int               FTQ_DEPTH = 4
) (
    input  logic                                          clk,
    input  logic                                          rst_n,

    // Backend
    input  logic                                          flush_i,
    input  fetch_pkg::addr_t                              flush_pc_i,
    input  logic                                          ib_stall_i,

    // CSR
    input  logic                                          csr_da_i,
    input  logic                                          csr_pg_i,
    input  csr_pkg::plv_t                                 csr_plv_i,
    input  csr_pkg::csr_word_t                            csr_dmw0_i,
    input  csr_pkg::csr_word_t                            csr_dmw1_i,

    // ICache, fixed dual port
    output logic [1:0]                                    icache_rd_req_o,
    output fetch_pkg::addr_t [1:0]                        icache_rd_addr_o,
    input  logic [1:0]                                    icache_rd_valid_i,
    input  fetch_pkg::line_t [1:0]                        icache_rd_data_i,

    // Instruction buffer
    output logic [fetch_pkg::FETCH_WIDTH-1:0]             ib_valid_o,
    output fetch_pkg::addr_t [fetch_pkg::FETCH_WIDTH-1:0] ib_pc_o,
    output fetch_pkg::instr_t [fetch_pkg::FETCH_WIDTH-1:0] ib_instr_o,
    output fetch_pkg::ecode_t                             ib_ecode_o
);

    logic             blk_valid;
    fetch_pkg::addr_t blk_pc;
    logic             blk_cross;
    logic             ftq_full;

    logic             head_valid;
    fetch_pkg::addr_t head_pc;
    logic             head_cross;
    logic             ifu_accept;

    pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush_i),
        .flush_pc_i  (flush_pc_i),
        .ftq_full_i  (ftq_full),
        .blk_valid_o (blk_valid),
        .blk_pc_o    (blk_pc),
        .blk_cross_o (blk_cross)
    );

    ftq #(
        .FTQ_DEPTH (FTQ_DEPTH)
    ) u_ftq (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (flush_i),
        .enq_valid_i  (blk_valid),
        .enq_pc_i     (blk_pc),
        .enq_cross_i  (blk_cross),
        .full_o       (ftq_full),
        .deq_accept_i (ifu_accept),
        .head_valid_o (head_valid),
        .head_pc_o    (head_pc),
        .head_cross_o (head_cross)
    );

    ifu u_ifu (
        .clk               (clk),
        .rst_n             (rst_n),
        .flush_i           (flush_i),
        .head_valid_i      (head_valid),
        .head_pc_i         (head_pc),
        .head_cross_i      (head_cross),
        .accept_o          (ifu_accept),
        .csr_da_i          (csr_da_i),
        .csr_pg_i          (csr_pg_i),
        .csr_plv_i         (csr_plv_i),
        .csr_dmw0_i        (csr_dmw0_i),
        .csr_dmw1_i        (csr_dmw1_i),
        .icache_rd_req_o   (icache_rd_req_o),
        .icache_rd_addr_o  (icache_rd_addr_o),
        .icache_rd_valid_i (icache_rd_valid_i),
        .icache_rd_data_i  (icache_rd_data_i),
        .ib_stall_i        (ib_stall_i),
        .ib_valid_o        (ib_valid_o),
        .ib_pc_o           (ib_pc_o),
        .ib_instr_o        (ib_instr_o),
        .ib_ecode_o        (ib_ecode_o)
    );

endmodule

/* logic/ifu.sv */
`timescale 1ns/10ps

module ifu (
    input  logic                                        clk,
    input  logic                                        rst_n,

    input  logic                                        flush_i,

    // Queue head
    input  logic                                        head_valid_i,
    input  fetch_pkg::addr_t                            head_pc_i,
    input  logic                                        head_cross_i,
    output logic                                        accept_o,

    input  logic                                        csr_da_i,
    input  logic                                        csr_pg_i,
    input  csr_pkg::plv_t                               csr_plv_i,
    input  csr_pkg::csr_word_t                          csr_dmw0_i,
    input  csr_pkg::csr_word_t                          csr_dmw1_i,

    // Dual-port ICache
    output logic [1:0]                                  icache_rd_req_o,
    output fetch_pkg::addr_t [1:0]                      icache_rd_addr_o,
    input  logic [1:0]                                  icache_rd_valid_i,
    input  fetch_pkg::line_t [1:0]                      icache_rd_data_i,

    // Instruction buffer
    input  logic                                        ib_stall_i,
    output logic [fetch_pkg::FETCH_WIDTH-1:0]           ib_valid_o,
    output fetch_pkg::addr_t [fetch_pkg::FETCH_WIDTH-1:0] ib_pc_o,
    output fetch_pkg::instr_t [fetch_pkg::FETCH_WIDTH-1:0] ib_instr_o,
    output fetch_pkg::ecode_t                           ib_ecode_o
);

    fetch_pkg::ifu_state_e state_q;
    fetch_pkg::ifu_state_e state_d;

    logic [1:0] pending_q;
    logic [1:0] pending_d;
    logic [1:0] rd_req_q;
    logic [1:0] rd_req_d;

    fetch_pkg::addr_t  xl_paddr;
    fetch_pkg::ecode_t xl_ecode;

    fetch_pkg::addr_t [1:0] rd_addr_q;
    fetch_pkg::addr_t       pc_q;
    fetch_pkg::ecode_t      ecode_q;
    logic [1:0]             word_sel_q;
    fetch_pkg::line_t [1:0] line_q;

    logic [2*fetch_pkg::LINE_W-1:0] line_pair;
    logic [2:0]                     sel0;
    logic [2:0]                     sel1;
    logic                           fault;

    addr_xlate u_addr_xlate (
        .vaddr_i    (head_pc_i),
        .csr_da_i   (csr_da_i),
        .csr_pg_i   (csr_pg_i),
        .csr_plv_i  (csr_plv_i),
        .csr_dmw0_i (csr_dmw0_i),
        .csr_dmw1_i (csr_dmw1_i),
        .paddr_o    (xl_paddr),
        .ecode_o    (xl_ecode)
    );

    // Head is consumed in XLATE unless a flush clears the queue anyway
    assign accept_o = (state_q == fetch_pkg::XLATE) && !flush_i;

    always_comb begin
        state_d   = state_q;
        pending_d = pending_q & ~icache_rd_valid_i;
        rd_req_d  = '0;
        case (state_q)
            fetch_pkg::IDLE: begin
                if (head_valid_i && !flush_i) begin
                    state_d = fetch_pkg::XLATE;
                end
            end
            fetch_pkg::XLATE: begin
                if (flush_i) begin
                    state_d = fetch_pkg::IDLE;
                end else if (xl_ecode != '0) begin
                    // Faulting block skips the cache
                    state_d = fetch_pkg::OUTPUT;
                end else begin
                    rd_req_d  = {head_cross_i, 1'b1};
                    pending_d = {head_cross_i, 1'b1};
                    state_d   = fetch_pkg::WAIT_RD;
                end
            end
            fetch_pkg::WAIT_RD: begin
                if (flush_i) begin
                    state_d = (pending_d != '0) ? fetch_pkg::DRAIN : fetch_pkg::IDLE;
                end else if (pending_d == '0) begin
                    state_d = fetch_pkg::OUTPUT;
                end
            end
            fetch_pkg::OUTPUT: begin
                if (flush_i) begin
                    state_d = fetch_pkg::IDLE;
                end else if (!ib_stall_i) begin
                    state_d = head_valid_i ? fetch_pkg::XLATE : fetch_pkg::IDLE;
                end
            end
            fetch_pkg::DRAIN: begin
                if (pending_d == '0) begin
                    state_d = fetch_pkg::IDLE;
                end
            end
            default: state_d = fetch_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= fetch_pkg::IDLE;
            pending_q <= '0;
            rd_req_q  <= '0;
        end else begin
            state_q   <= state_d;
            pending_q <= pending_d;
            rd_req_q  <= rd_req_d;
        end
    end

    // Block and line capture
    always_ff @(posedge clk) begin
        if (state_q == fetch_pkg::XLATE) begin
            pc_q         <= head_pc_i;
            ecode_q      <= xl_ecode;
            word_sel_q   <= xl_paddr[3:2];
            rd_addr_q[0] <= {xl_paddr[31:4], 4'b0000};
            rd_addr_q[1] <= {xl_paddr[31:4] + 28'd1, 4'b0000};
        end
        for (int p = 0; p < 2; p++) begin
            if (icache_rd_valid_i[p] && (state_q == fetch_pkg::WAIT_RD)) begin
                line_q[p] <= icache_rd_data_i[p];
            end
        end
    end

    assign icache_rd_req_o  = rd_req_q;
    assign icache_rd_addr_o = rd_addr_q;

    // Eight words across both lines; slot 1 may spill into line 1
    assign line_pair = line_q;
    assign sel0      = {1'b0, word_sel_q};
    assign sel1      = sel0 + 3'd1;
    assign fault     = (ecode_q != '0);

    always_comb begin
        ib_valid_o = '0;
        if ((state_q == fetch_pkg::OUTPUT) && !ib_stall_i && !flush_i) begin
            ib_valid_o = {!fault, 1'b1};
        end
    end

    assign ib_pc_o[0]    = pc_q;
    assign ib_pc_o[1]    = pc_q + 32'd4;
    assign ib_instr_o[0] = fault ? '0 : line_pair[sel0*fetch_pkg::INSTR_W +: fetch_pkg::INSTR_W];
    assign ib_instr_o[1] = fault ? '0 : line_pair[sel1*fetch_pkg::INSTR_W +: fetch_pkg::INSTR_W];
    assign ib_ecode_o    = ecode_q;

endmodule

/* logic/addr_xlate.sv */
`timescale 1ns/10ps

module addr_xlate (
    input  fetch_pkg::addr_t    vaddr_i,

    input  logic                csr_da_i,
    input  logic                csr_pg_i,
    input  csr_pkg::plv_t       csr_plv_i,
    input  csr_pkg::csr_word_t  csr_dmw0_i,
    input  csr_pkg::csr_word_t  csr_dmw1_i,

    output fetch_pkg::addr_t    paddr_o,
    output fetch_pkg::ecode_t   ecode_o
);

    logic dmw0_hit;
    logic dmw1_hit;
    logic mapped;
    logic adef;

    // Window enabled for this level and VSEG matches the top bits
    function automatic logic dmw_match(input csr_pkg::csr_word_t dmw,
                                       input csr_pkg::plv_t plv,
                                       input fetch_pkg::addr_t va);
        logic plv_ok;
        plv_ok = (dmw[csr_pkg::DMW_PLV0_BIT] && (plv == csr_pkg::PLV_KERNEL)) ||
                 (dmw[csr_pkg::DMW_PLV3_BIT] && (plv == csr_pkg::PLV_USER));
        return plv_ok && (va[fetch_pkg::ADDR_W-1 -: csr_pkg::DMW_SEG_W] ==
                          dmw[csr_pkg::DMW_VSEG_LSB +: csr_pkg::DMW_SEG_W]);
    endfunction

    assign dmw0_hit = csr_pg_i && dmw_match(csr_dmw0_i, csr_plv_i, vaddr_i);
    assign dmw1_hit = csr_pg_i && dmw_match(csr_dmw1_i, csr_plv_i, vaddr_i);

    // Would need the TLB
    assign mapped = csr_pg_i && !csr_da_i && !dmw0_hit && !dmw1_hit;

    assign adef = (vaddr_i[1:0] != 2'b00) ||
                  ((csr_plv_i == csr_pkg::PLV_USER) && vaddr_i[fetch_pkg::ADDR_W-1] && mapped);

    always_comb begin
        paddr_o = vaddr_i;
        ecode_o = '0;
        if (adef) begin
            ecode_o[fetch_pkg::ECODE_ADEF_BIT] = 1'b1;
        end else if (csr_da_i) begin
            paddr_o = vaddr_i;
        end else if (dmw0_hit) begin
            // DMW0 wins when both windows match
            paddr_o = {csr_dmw0_i[csr_pkg::DMW_PSEG_LSB +: csr_pkg::DMW_SEG_W], vaddr_i[28:0]};
        end else if (dmw1_hit) begin
            paddr_o = {csr_dmw1_i[csr_pkg::DMW_PSEG_LSB +: csr_pkg::DMW_SEG_W], vaddr_i[28:0]};
        end else begin
            ecode_o[fetch_pkg::ECODE_TLBR_BIT] = 1'b1;
        end
    end

endmodule

/* logic/ftq.sv */
`timescale 1ns/10ps

module ftq #(
    parameter int FTQ_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,

    input  logic             flush_i,

    // Enqueue side from PC generation
    input  logic             enq_valid_i,
    input  fetch_pkg::addr_t enq_pc_i,
    input  logic             enq_cross_i,
    output logic             full_o,

    // Head of queue towards the IFU
    input  logic             deq_accept_i,
    output logic             head_valid_o,
    output fetch_pkg::addr_t head_pc_o,
    output logic             head_cross_o
);

    localparam int PTR_W = $clog2(FTQ_DEPTH);
    localparam logic [PTR_W:0] DEPTH_CNT = FTQ_DEPTH[PTR_W:0];

    fetch_pkg::addr_t pc_mem [FTQ_DEPTH];
    logic             cross_mem [FTQ_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;

    logic enq;
    logic deq;

    assign full_o       = (count_q == DEPTH_CNT);
    assign head_valid_o = (count_q != '0);

    assign enq = enq_valid_i && !full_o;
    assign deq = deq_accept_i && head_valid_o;

    assign head_pc_o    = pc_mem[rd_ptr_q];
    assign head_cross_o = cross_mem[rd_ptr_q];

    // Entry storage
    always_ff @(posedge clk) begin
        if (enq) begin
            pc_mem[wr_ptr_q]    <= enq_pc_i;
            cross_mem[wr_ptr_q] <= enq_cross_i;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (enq) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (deq) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({enq, deq})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* logic/pc_gen.sv */
`timescale 1ns/10ps

module pc_gen #(
    parameter fetch_pkg::addr_t RESET_PC = 32'h1c00_0000
) (
    input  logic             clk,
    input  logic             rst_n,

    input  logic             flush_i,
    input  fetch_pkg::addr_t flush_pc_i,
    input  logic             ftq_full_i,

    output logic             blk_valid_o,
    output fetch_pkg::addr_t blk_pc_o,
    output logic             blk_cross_o
);

    localparam fetch_pkg::addr_t BLK_BYTES = fetch_pkg::addr_t'(fetch_pkg::FETCH_WIDTH * 4);

    fetch_pkg::addr_t pc_q;
    fetch_pkg::addr_t pc_d;

    // Flush first, then hold on a full queue, else next block
    always_comb begin
        if (flush_i) begin
            pc_d = flush_pc_i;
        end else if (ftq_full_i) begin
            pc_d = pc_q;
        end else begin
            pc_d = pc_q + BLK_BYTES;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    // One block per cycle while the queue has room
    assign blk_valid_o = !ftq_full_i && !flush_i;
    assign blk_pc_o    = pc_q;

    // Last word of a line, so slot 1 sits in the next line
    assign blk_cross_o = &pc_q[3:2];

endmodule

/* logic/csr_pkg.sv */
package csr_pkg;

    typedef logic [31:0] csr_word_t;

    // Privilege level
    typedef logic [1:0] plv_t;

    localparam plv_t PLV_KERNEL = 2'd0;
    localparam plv_t PLV_USER   = 2'd3;

    // DMW window enables per privilege level
    localparam int DMW_PLV0_BIT = 0;
    localparam int DMW_PLV3_BIT = 3;

    // Segment fields of a DMW word, three bits each
    localparam int DMW_SEG_W    = 3;
    localparam int DMW_PSEG_LSB = 25;
    localparam int DMW_VSEG_LSB = 29;

endpackage

/* logic/fetch_pkg.sv */
package fetch_pkg;

    // Instructions per fetch block
    // The line-split logic in the IFU assumes exactly two slots
    localparam int FETCH_WIDTH = 2;

    localparam int ADDR_W  = 32;
    localparam int INSTR_W = 32;

    // ICache line holds four words
    localparam int LINE_W = 128;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [INSTR_W-1:0] instr_t;
    typedef logic [LINE_W-1:0]  line_t;

    // One-hot fetch exception flags
    // Bits 2 and 3 (PIF, PPI) need the TLB and stay zero
    typedef logic [3:0] ecode_t;

    localparam int ECODE_ADEF_BIT = 0;
    localparam int ECODE_TLBR_BIT = 1;

    typedef enum logic [2:0] {
        IDLE,
        XLATE,
        WAIT_RD,
        OUTPUT,
        DRAIN
    } ifu_state_e;

endpackage
